/* hw/avr_settings.svh */
`ifndef AVR_SETTINGS_SVH
`define AVR_SETTINGS_SVH

// widths fixed by the instruction encoding
`define AVR_WORD_W   16
`define AVR_DATA_W   8
`define AVR_NUM_REGS 32
`define AVR_REG_AW   5

// pointer pairs, high byte sits at index + 1
`define AVR_Y_LO 28
`define AVR_Z_LO 30

// status register bits
`define AVR_FLAG_C 0
`define AVR_FLAG_Z 1
`define AVR_FLAG_N 2
`define AVR_FLAG_V 3
`define AVR_FLAG_S 4
`define AVR_FLAG_H 5
`define AVR_FLAG_T 6
`define AVR_FLAG_I 7

`endif

/* hw/avr_pkg.sv */
`default_nettype none

package avr_pkg;

	// execution ops, unknown words collapse to OP_NOP
	typedef enum logic [4:0] {
		OP_NOP,
		OP_ADD,
		OP_ADC,
		OP_SUB,
		OP_SBC,
		OP_SUBI,
		OP_SBCI,
		OP_AND,
		OP_ANDI,
		OP_OR,
		OP_ORI,
		OP_EOR,
		OP_MOV,
		OP_LDI,
		OP_SWAP,
		OP_LSR,
		OP_CP,
		OP_CPI,
		OP_RJMP,
		OP_BRANCH, // BRBS and BRBC
		OP_LOAD,   // LDD through Y or Z
		OP_STORE   // STD through Y or Z
	} opcode_t;

	typedef enum logic [1:0] {
		PC_HOLD,
		PC_STEP,
		PC_REL
	} pc_sel_t;

	typedef enum logic {
		MS_ADDR, // address out, pc held
		MS_DATA  // read data valid or write strobe
	} mem_state_t;

endpackage

`default_nettype wire

/* hw/avr_fetch.sv */
`timescale 1ns/1ps
`default_nettype none
`include "avr_settings.svh"

module avr_fetch (
	input  wire                     CLK,
	input  wire                     RST,
	input  wire avr_pkg::pc_sel_t   pc_sel,
	input  wire [`AVR_WORD_W-1:0]   rel_offset,
	output logic [`AVR_WORD_W-1:0]  prog_addr
);
	import avr_pkg::*;

	logic [`AVR_WORD_W-1:0] pc;      // address of the word now on prog_data
	logic [`AVR_WORD_W-1:0] pc_next;

	always_comb begin
		case (pc_sel)
			PC_HOLD: pc_next = pc;                        // second cycle of a memory op
			PC_REL:  pc_next = pc + 1'b1 + rel_offset;    // rjmp or taken branch
			default: pc_next = pc + 1'b1;
		endcase
	end

	// rom latches the next pc, so word 0 has to be addressed while in reset
	assign prog_addr = RST ? '0 : pc_next;

	always_ff @(posedge CLK) begin
		if (RST)
			pc <= '0;
		else
			pc <= pc_next;
	end

	// sequencer must pick a defined source every cycle once running
	a_pc_sel_known: assert property (@(posedge CLK) disable iff (RST)
		!$isunknown(pc_sel));

endmodule

`default_nettype wire

/* hw/avr_decode.sv */
`timescale 1ns/1ps
`default_nettype none
`include "avr_settings.svh"

module avr_decode (
	input  wire [`AVR_WORD_W-1:0]  instr,
	output avr_pkg::opcode_t       op,
	output logic [`AVR_REG_AW-1:0] rd_addr,
	output logic [`AVR_REG_AW-1:0] rr_addr,
	output logic [`AVR_DATA_W-1:0] imm8,
	output logic [5:0]             disp6,
	output logic                   ptr_is_y,
	output logic [2:0]             branch_bit,
	output logic                   branch_if_set,
	output logic [`AVR_WORD_W-1:0] rel_offset
);
	import avr_pkg::*;

	always_comb begin
		op = OP_NOP;
		rd_addr = instr[8:4];
		casez (instr)
			16'b0000_11??_????_????: op = OP_ADD;
			16'b0001_11??_????_????: op = OP_ADC;
			16'b0001_10??_????_????: op = OP_SUB;
			16'b0000_10??_????_????: op = OP_SBC;
			16'b0001_01??_????_????: op = OP_CP;
			16'b0010_00??_????_????: op = OP_AND;
			16'b0010_01??_????_????: op = OP_EOR;
			16'b0010_10??_????_????: op = OP_OR;
			16'b0010_11??_????_????: op = OP_MOV;
			16'b0011_????_????_????: op = OP_CPI;
			16'b0100_????_????_????: op = OP_SBCI;
			16'b0101_????_????_????: op = OP_SUBI;
			16'b0110_????_????_????: op = OP_ORI;
			16'b0111_????_????_????: op = OP_ANDI;
			16'b1110_????_????_????: op = OP_LDI;
			16'b1001_010?_????_0010: op = OP_SWAP;
			16'b1001_010?_????_0110: op = OP_LSR;
			16'b10?0_??0?_????_????: op = OP_LOAD;  // bit 3 picks Y or Z
			16'b10?0_??1?_????_????: op = OP_STORE;
			16'b1100_????_????_????: op = OP_RJMP;
			16'b1111_0???_????_????: op = OP_BRANCH; // bit 10 set means BRBC
			default:                 op = OP_NOP;
		endcase

		// immediate forms only reach r16..r31
		if (op inside {OP_SUBI, OP_SBCI, OP_ANDI, OP_ORI, OP_CPI, OP_LDI})
			rd_addr = {1'b1, instr[7:4]};
	end

	assign rr_addr       = {instr[9], instr[3:0]};
	assign imm8          = {instr[11:8], instr[3:0]};
	assign disp6         = {instr[13], instr[11:10], instr[2:0]};
	assign ptr_is_y      = instr[3];
	assign branch_bit    = instr[2:0];
	assign branch_if_set = ~instr[10];

	// 12 bit rjmp offset or 7 bit branch offset, both in words
	assign rel_offset = (op == OP_RJMP) ? {{4{instr[11]}}, instr[11:0]}
	                                    : {{9{instr[9]}}, instr[9:3]};

endmodule

`default_nettype wire

/* hw/avr_regfile.sv */
`timescale 1ns/1ps
`default_nettype none
`include "avr_settings.svh"

module avr_regfile (
	input  wire                    CLK,
	input  wire                    RST,
	input  wire [`AVR_REG_AW-1:0]  rd_addr,
	input  wire [`AVR_REG_AW-1:0]  rr_addr,
	output logic [`AVR_DATA_W-1:0] rd_data,
	output logic [`AVR_DATA_W-1:0] rr_data,
	input  wire                    reg_we,
	input  wire [`AVR_DATA_W-1:0]  reg_wdata,
	output logic [`AVR_WORD_W-1:0] y_ptr,
	output logic [`AVR_WORD_W-1:0] z_ptr
);

	logic [`AVR_DATA_W-1:0] regs [`AVR_NUM_REGS];

	always_ff @(posedge CLK) begin
		if (RST) begin
			for (int i = 0; i < `AVR_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (reg_we) begin
			regs[rd_addr] <= reg_wdata; // writeback always targets Rd
		end
	end

	assign rd_data = regs[rd_addr];
	assign rr_data = regs[rr_addr];

	// pointer pairs, low byte at the even index
	assign y_ptr = {regs[`AVR_Y_LO + 1], regs[`AVR_Y_LO]};
	assign z_ptr = {regs[`AVR_Z_LO + 1], regs[`AVR_Z_LO]};

	// write enable from the sequencer must come with a decoded destination
	a_write_addr_known: assert property (@(posedge CLK) disable iff (RST)
		reg_we |-> !$isunknown(rd_addr) && !$isunknown(reg_wdata));

endmodule

`default_nettype wire

/* hw/avr_alu.sv */
`timescale 1ns/1ps
`default_nettype none
`include "avr_settings.svh"

module avr_alu (
	input  wire                    CLK,
	input  wire                    RST,
	input  wire avr_pkg::opcode_t  op,
	input  wire [`AVR_DATA_W-1:0]  rd_data,
	input  wire [`AVR_DATA_W-1:0]  rr_data,
	input  wire [`AVR_DATA_W-1:0]  imm8,
	input  wire [2:0]              branch_bit,
	input  wire                    branch_if_set,
	output logic [`AVR_DATA_W-1:0] alu_result,
	output logic                   branch_taken
);
	import avr_pkg::*;

	logic [`AVR_DATA_W-1:0] sreg;
	logic [`AVR_DATA_W-1:0] flags;   // next status value
	logic                   flag_we;
	logic [`AVR_DATA_W-1:0] opb;
	logic                   cin;
	logic [`AVR_DATA_W:0]   sum;     // bit 8 is carry out
	logic [`AVR_DATA_W:0]   dif;     // bit 8 is borrow out
	logic [4:0]             sum_lo;
	logic [4:0]             dif_lo;

	assign opb = (op inside {OP_SUBI, OP_SBCI, OP_ANDI, OP_ORI, OP_CPI}) ? imm8 : rr_data;
	assign cin = (op inside {OP_ADC, OP_SBC, OP_SBCI}) & sreg[`AVR_FLAG_C];

	assign sum    = {1'b0, rd_data} + {1'b0, opb} + {8'd0, cin};
	assign dif    = {1'b0, rd_data} - {1'b0, opb} - {8'd0, cin};
	assign sum_lo = {1'b0, rd_data[3:0]} + {1'b0, opb[3:0]} + {4'd0, cin};
	assign dif_lo = {1'b0, rd_data[3:0]} - {1'b0, opb[3:0]} - {4'd0, cin};

	always_comb begin
		alu_result = rd_data;
		flags = sreg;
		flag_we = 1'b0;
		case (op)
			OP_ADD, OP_ADC: begin
				alu_result = sum[7:0];
				flags[`AVR_FLAG_C] = sum[8];
				flags[`AVR_FLAG_H] = sum_lo[4];
				flags[`AVR_FLAG_V] = (rd_data[7] & opb[7] & ~sum[7])
					| (~rd_data[7] & ~opb[7] & sum[7]);
				flag_we = 1'b1;
			end
			OP_SUB, OP_SBC, OP_SUBI, OP_SBCI, OP_CP, OP_CPI: begin
				alu_result = dif[7:0]; // compares drop this in the sequencer
				flags[`AVR_FLAG_C] = dif[8];
				flags[`AVR_FLAG_H] = dif_lo[4];
				flags[`AVR_FLAG_V] = (rd_data[7] & ~opb[7] & ~dif[7])
					| (~rd_data[7] & opb[7] & dif[7]);
				flag_we = 1'b1;
			end
			OP_AND, OP_ANDI: begin
				alu_result = rd_data & opb;
				flags[`AVR_FLAG_V] = 1'b0;
				flag_we = 1'b1;
			end
			OP_OR, OP_ORI: begin
				alu_result = rd_data | opb;
				flags[`AVR_FLAG_V] = 1'b0;
				flag_we = 1'b1;
			end
			OP_EOR: begin
				alu_result = rd_data ^ rr_data;
				flags[`AVR_FLAG_V] = 1'b0;
				flag_we = 1'b1;
			end
			OP_MOV:  alu_result = rr_data;
			OP_LDI:  alu_result = imm8;
			OP_SWAP: alu_result = {rd_data[3:0], rd_data[7:4]};
			OP_LSR: begin
				alu_result = {1'b0, rd_data[7:1]};
				flags[`AVR_FLAG_C] = rd_data[0];
				flags[`AVR_FLAG_V] = rd_data[0]; // N is always 0 here, so V = C
				flag_we = 1'b1;
			end
			default: ;
		endcase

		// common to every flag writer
		if (flag_we) begin
			flags[`AVR_FLAG_Z] = (alu_result == '0);
			flags[`AVR_FLAG_N] = alu_result[7];
			flags[`AVR_FLAG_S] = flags[`AVR_FLAG_N] ^ flags[`AVR_FLAG_V];
		end
	end

	always_ff @(posedge CLK) begin
		if (RST)
			sreg <= '0;
		else if (flag_we)
			sreg <= flags;
	end

	assign branch_taken = (op == OP_BRANCH) && (sreg[branch_bit] == branch_if_set);

endmodule

`default_nettype wire

/* hw/avr_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "avr_settings.svh"

module avr_sequencer (
	input  wire                    CLK,
	input  wire                    RST,
	input  wire avr_pkg::opcode_t  op,
	input  wire                    branch_taken,
	input  wire [`AVR_DATA_W-1:0]  alu_result,
	input  wire [`AVR_DATA_W-1:0]  data_rdata,
	input  wire [`AVR_DATA_W-1:0]  rd_data,
	input  wire [`AVR_WORD_W-1:0]  y_ptr,
	input  wire [`AVR_WORD_W-1:0]  z_ptr,
	input  wire [5:0]              disp6,
	input  wire                    ptr_is_y,
	output avr_pkg::pc_sel_t       pc_sel,
	output logic                   reg_we,
	output logic [`AVR_DATA_W-1:0] reg_wdata,
	output logic [`AVR_WORD_W-1:0] data_addr,
	output logic [`AVR_DATA_W-1:0] data_wdata,
	output logic                   data_we
);
	import avr_pkg::*;

	mem_state_t state;
	logic       is_mem;

	assign is_mem = (op == OP_LOAD) || (op == OP_STORE);

	always_ff @(posedge CLK) begin
		if (RST)
			state <= MS_ADDR;
		else if (is_mem && state == MS_ADDR)
			state <= MS_DATA;
		else
			state <= MS_ADDR;
	end

	// address stays put across both cycles since the word is held
	assign data_addr  = (ptr_is_y ? y_ptr : z_ptr) + {{(`AVR_WORD_W - 6){1'b0}}, disp6};
	assign data_wdata = rd_data;
	assign data_we    = (op == OP_STORE) && (state == MS_DATA);

	// compares, branches, jumps, nop and stores leave the file alone
	assign reg_we = (op inside {OP_ADD, OP_ADC, OP_SUB, OP_SBC, OP_SUBI, OP_SBCI,
		OP_AND, OP_ANDI, OP_OR, OP_ORI, OP_EOR, OP_MOV, OP_LDI, OP_SWAP, OP_LSR})
		|| ((op == OP_LOAD) && (state == MS_DATA));
	assign reg_wdata = (op == OP_LOAD) ? data_rdata : alu_result;

	always_comb begin
		if (is_mem && state == MS_ADDR)
			pc_sel = PC_HOLD;
		else if (op == OP_RJMP || branch_taken)
			pc_sel = PC_REL;
		else
			pc_sel = PC_STEP;
	end

	// strobe belongs to the same store word that set up the address a cycle earlier
	a_store_strobe: assert property (@(posedge CLK) disable iff (RST)
		data_we |-> $past(op) == OP_STORE && $stable(data_addr));

endmodule

`default_nettype wire

/* hw/avr_core.sv */
`timescale 1ns/1ps
`default_nettype none
`include "avr_settings.svh"

module avr_core (
	input  wire                    CLK,
	input  wire                    RST,
	output logic [`AVR_WORD_W-1:0] prog_addr,
	input  wire [`AVR_WORD_W-1:0]  prog_data,
	output logic [`AVR_WORD_W-1:0] data_addr,
	output logic [`AVR_DATA_W-1:0] data_wdata,
	output logic                   data_we,
	input  wire [`AVR_DATA_W-1:0]  data_rdata
);
	import avr_pkg::*;

	// decoded fields
	opcode_t                op;
	logic [`AVR_REG_AW-1:0] rd_addr;
	logic [`AVR_REG_AW-1:0] rr_addr;
	logic [`AVR_DATA_W-1:0] imm8;
	logic [5:0]             disp6;
	logic                   ptr_is_y;
	logic [2:0]             branch_bit;
	logic                   branch_if_set;
	logic [`AVR_WORD_W-1:0] rel_offset;

	// register file
	logic [`AVR_DATA_W-1:0] rd_data;
	logic [`AVR_DATA_W-1:0] rr_data;
	logic [`AVR_WORD_W-1:0] y_ptr;
	logic [`AVR_WORD_W-1:0] z_ptr;
	logic                   reg_we;
	logic [`AVR_DATA_W-1:0] reg_wdata;

	// execute and control
	logic [`AVR_DATA_W-1:0] alu_result;
	logic                   branch_taken;
	pc_sel_t                pc_sel;

	avr_fetch fetch0 (
		.CLK        (CLK),
		.RST        (RST),
		.pc_sel     (pc_sel),
		.rel_offset (rel_offset),
		.prog_addr  (prog_addr)
	);

	// rom output is the current instruction, no extra register
	avr_decode decode0 (
		.instr         (prog_data),
		.op            (op),
		.rd_addr       (rd_addr),
		.rr_addr       (rr_addr),
		.imm8          (imm8),
		.disp6         (disp6),
		.ptr_is_y      (ptr_is_y),
		.branch_bit    (branch_bit),
		.branch_if_set (branch_if_set),
		.rel_offset    (rel_offset)
	);

	avr_regfile regs0 (
		.CLK       (CLK),
		.RST       (RST),
		.rd_addr   (rd_addr),
		.rr_addr   (rr_addr),
		.rd_data   (rd_data),
		.rr_data   (rr_data),
		.reg_we    (reg_we),
		.reg_wdata (reg_wdata),
		.y_ptr     (y_ptr),
		.z_ptr     (z_ptr)
	);

	avr_alu alu0 (
		.CLK           (CLK),
		.RST           (RST),
		.op            (op),
		.rd_data       (rd_data),
		.rr_data       (rr_data),
		.imm8          (imm8),
		.branch_bit    (branch_bit),
		.branch_if_set (branch_if_set),
		.alu_result    (alu_result),
		.branch_taken  (branch_taken)
	);

	avr_sequencer seq0 (
		.CLK          (CLK),
		.RST          (RST),
		.op           (op),
		.branch_taken (branch_taken),
		.alu_result   (alu_result),
		.data_rdata   (data_rdata),
		.rd_data      (rd_data),
		.y_ptr        (y_ptr),
		.z_ptr        (z_ptr),
		.disp6        (disp6),
		.ptr_is_y     (ptr_is_y),
		.pc_sel       (pc_sel),
		.reg_we       (reg_we),
		.reg_wdata    (reg_wdata),
		.data_addr    (data_addr),
		.data_wdata   (data_wdata),
		.data_we      (data_we)
	);

endmodule

`default_nettype wire

/* bench/avr_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module avr_core_tb;

	localparam int MAX_CYCLES = 3000; // all programs together run a few hundred cycles

	logic        CLK;
	logic        RST;
	logic [15:0] prog_data;
	logic [7:0]  data_rdata;
	wire  [15:0] prog_addr;
	wire  [15:0] data_addr;
	wire  [7:0]  data_wdata;
	wire         data_we;

	logic [15:0] rom [0:1023];
	logic [7:0]  ram [0:65535];
	logic [15:0] pa;        // next free rom word
	logic [15:0] zbase;
	logic [15:0] rec_addr [$];
	logic [7:0]  rec_data [$];
	logic [15:0] exp_addr [$];
	logic [7:0]  exp_data [$];
	int          errors = 0;
	int          cycles = 0;

	avr_core dut0 (
		.CLK        (CLK),
		.RST        (RST),
		.prog_addr  (prog_addr),
		.prog_data  (prog_data),
		.data_addr  (data_addr),
		.data_wdata (data_wdata),
		.data_we    (data_we),
		.data_rdata (data_rdata)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	// synchronous rom and ram, one cycle read latency
	always @(posedge CLK) begin
		prog_data <= rom[prog_addr[9:0]];
		if (data_we)
			ram[data_addr] <= data_wdata;
		data_rdata <= ram[data_addr];
		if (!RST && data_we !== 1'b0) begin
			rec_addr.push_back(data_addr);
			rec_data.push_back(data_wdata);
		end
	end

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: a program never reached its final jump in %0d cycles", MAX_CYCLES);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	function automatic logic [15:0] alu_rr(input logic [15:0] base, input logic [4:0] d,
		input logic [4:0] r);
		return base | {6'd0, r[4], d, r[3:0]};
	endfunction

	function automatic logic [15:0] alu_imm(input logic [15:0] base, input logic [4:0] d,
		input logic [7:0] k);
		return base | {4'd0, k[7:4], d[3:0], k[3:0]}; // only r16..r31
	endfunction

	function automatic logic [15:0] ldi(input logic [4:0] d, input logic [7:0] k);
		return alu_imm(16'hE000, d, k);
	endfunction

	function automatic logic [15:0] unary(input logic [15:0] base, input logic [4:0] d);
		return base | {7'd0, d, 4'd0};
	endfunction

	function automatic logic [15:0] ldd_std(input logic store, input logic use_y,
		input logic [4:0] d, input logic [5:0] q);
		return {2'b10, q[5], 1'b0, q[4:3], store, d, use_y, q[2:0]};
	endfunction

	function automatic logic [15:0] rjmp_to(input logic [11:0] k);
		return {4'hC, k};
	endfunction

	function automatic logic [15:0] branch_on(input logic set, input logic [2:0] s,
		input logic [6:0] k);
		return {5'b11110, ~set, k, s};
	endfunction

	// architectural flags of a - b
	function automatic logic [7:0] cmp_flags(input logic [7:0] a, input logic [7:0] b);
		int sa;
		int sb;
		int d;
		logic [7:0] r;
		logic [7:0] f;
		r = a - b;
		sa = a[7] ? int'(a) - 256 : int'(a);
		sb = b[7] ? int'(b) - 256 : int'(b);
		d = sa - sb;
		f = 8'd0;
		f[0] = b > a;
		f[1] = r == 8'd0;
		f[2] = r[7];
		f[3] = d < -128 || d > 127;
		f[4] = f[2] ^ f[3];
		f[5] = b[3:0] > a[3:0];
		return f;
	endfunction

	task automatic emit(input logic [15:0] w);
		rom[pa[9:0]] = w;
		pa = pa + 16'd1;
	endtask

	task automatic new_program();
		@(posedge CLK);
		RST <= 1'b1;
		for (int i = 0; i < 1024; i++)
			rom[i] = 16'h0000;
		pa = 16'd0;
		exp_addr.delete();
		exp_data.delete();
	endtask

	task automatic set_z(input logic [15:0] b);
		emit(ldi(5'd30, b[7:0]));
		emit(ldi(5'd31, b[15:8]));
		zbase = b;
	endtask

	task automatic store_expect(input logic [4:0] d, input logic [5:0] q, input logic [7:0] v);
		emit(ldd_std(1'b1, 1'b0, d, q));
		exp_addr.push_back(zbase + {10'd0, q});
		exp_data.push_back(v);
	endtask

	// r18 gets a taken or fall-through marker, then goes to Z+q
	task automatic branch_check(input logic [2:0] s, input logic set, input logic [5:0] q,
		input logic [7:0] f);
		emit(branch_on(set, s, 7'd2));
		emit(ldi(5'd18, 8'h80 + {2'b00, q}));
		emit(rjmp_to(12'd1));
		emit(ldi(5'd18, 8'h40 + {2'b00, q}));
		emit(ldd_std(1'b1, 1'b0, 5'd18, q));
		exp_addr.push_back(zbase + {10'd0, q});
		exp_data.push_back((f[s] == set) ? 8'h40 + {2'b00, q} : 8'h80 + {2'b00, q});
	endtask

	task automatic run_and_check(input string name);
		logic [15:0] end_addr;
		end_addr = pa;
		emit(rjmp_to(12'hFFF)); // jump to itself
		repeat (4) @(posedge CLK);
		rec_addr.delete();
		rec_data.delete();
		RST <= 1'b0;
		@(posedge CLK);
		while (prog_addr != end_addr)
			@(posedge CLK);
		repeat (3) @(posedge CLK);
		if (rec_addr.size() != exp_addr.size()) begin
			errors++;
			$display("** Error at %0t: %s made %0d stores, expected %0d", $time, name,
				rec_addr.size(), exp_addr.size());
		end
		for (int i = 0; i < rec_addr.size() && i < exp_addr.size(); i++) begin
			if (rec_addr[i] !== exp_addr[i] || rec_data[i] !== exp_data[i]) begin
				errors++;
				$display("** Error at %0t: %s store %0d wrote %h to %h, expected %h to %h",
					$time, name, i, rec_data[i], rec_addr[i], exp_data[i], exp_addr[i]);
			end
		end
	endtask

	task automatic test_store();
		logic [7:0] k [4];
		logic [5:0] q [4];
		q = '{6'd0, 6'd1, 6'd17, 6'd63};
		new_program();
		set_z(16'h0100);
		for (int i = 0; i < 4; i++) begin
			k[i] = 8'($urandom);
			emit(ldi(5'(16 + i), k[i]));
		end
		for (int i = 0; i < 4; i++)
			store_expect(5'(16 + i), q[i], k[i]);
		run_and_check("store");
	endtask

	task automatic model_add(inout logic [7:0] v, inout logic c, input logic [7:0] b,
		input logic cin);
		int t;
		t = int'(v) + int'(b) + int'(cin);
		c = t > 255;
		v = t[7:0];
	endtask

	task automatic model_sub(inout logic [7:0] v, inout logic c, input logic [7:0] b,
		input logic cin);
		int t;
		t = int'(v) - int'(b) - int'(cin);
		c = t < 0; // borrow
		v = t[7:0];
	endtask

	task automatic test_arith();
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] k1;
		logic [7:0] k2;
		logic [7:0] v;
		logic       c;
		a = 8'($urandom);
		b = 8'($urandom);
		k1 = 8'($urandom);
		k2 = 8'($urandom);
		v = a;
		c = 1'b0;
		new_program();
		set_z(16'h0180);
		emit(ldi(5'd16, a));
		emit(ldi(5'd17, b));
		emit(alu_rr(16'h0C00, 5'd16, 5'd17));
		model_add(v, c, b, 1'b0);
		store_expect(5'd16, 6'd0, v);
		emit(alu_rr(16'h1C00, 5'd16, 5'd17)); // adc
		model_add(v, c, b, c);
		store_expect(5'd16, 6'd1, v);
		emit(alu_rr(16'h1800, 5'd16, 5'd17)); // sub
		model_sub(v, c, b, 1'b0);
		store_expect(5'd16, 6'd2, v);
		emit(alu_rr(16'h0800, 5'd16, 5'd17)); // sbc
		model_sub(v, c, b, c);
		store_expect(5'd16, 6'd3, v);
		emit(alu_imm(16'h5000, 5'd16, k1));  // subi
		model_sub(v, c, k1, 1'b0);
		store_expect(5'd16, 6'd4, v);
		emit(alu_imm(16'h4000, 5'd16, k2));  // sbci
		model_sub(v, c, k2, c);
		store_expect(5'd16, 6'd5, v);
		run_and_check("arith");
	endtask

	task automatic test_logic();
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] k;
		logic [7:0] f;
		a = 8'($urandom);
		b = 8'($urandom);
		k = 8'($urandom);
		new_program();
		set_z(16'h0200);
		emit(ldi(5'd17, b));
		emit(ldi(5'd16, a));
		emit(alu_rr(16'h2000, 5'd16, 5'd17));
		store_expect(5'd16, 6'd0, a & b);
		emit(ldi(5'd16, a));
		emit(alu_imm(16'h7000, 5'd16, k));
		store_expect(5'd16, 6'd1, a & k);
		emit(ldi(5'd16, a));
		emit(alu_rr(16'h2800, 5'd16, 5'd17));
		store_expect(5'd16, 6'd2, a | b);
		emit(ldi(5'd16, a));
		emit(alu_imm(16'h6000, 5'd16, k));
		store_expect(5'd16, 6'd3, a | k);
		emit(ldi(5'd16, a));
		emit(alu_rr(16'h2400, 5'd16, 5'd17));
		store_expect(5'd16, 6'd4, a ^ b);
		emit(alu_rr(16'h2C00, 5'd16, 5'd17)); // mov
		store_expect(5'd16, 6'd5, b);
		emit(ldi(5'd16, a));
		emit(unary(16'h9402, 5'd16));         // swap
		store_expect(5'd16, 6'd6, {a[3:0], a[7:4]});
		emit(ldi(5'd16, a));
		emit(unary(16'h9406, 5'd16));         // lsr
		store_expect(5'd16, 6'd7, a >> 1);
		f = 8'd0;
		f[0] = a[0];
		f[1] = (a >> 1) == 8'd0;
		f[2] = 1'b0;   // lsr clears N
		f[3] = f[2] ^ f[0];
		f[4] = f[2] ^ f[3];
		branch_check(3'd0, 1'b1, 6'd8, f);
		branch_check(3'd3, 1'b0, 6'd9, f);
		branch_check(3'd1, 1'b1, 6'd10, f);
		run_and_check("logic");
	endtask

	task automatic test_branch();
		logic [7:0] pa_a [5];
		logic [7:0] pa_b [5];
		logic [7:0] f;
		pa_a = '{8'h05, 8'h10, 8'h80, 8'h08, 8'($urandom)};
		pa_b = '{8'h05, 8'h20, 8'h01, 8'h01, 8'($urandom)};
		new_program();
		set_z(16'h0280);
		for (int i = 0; i < 5; i++) begin
			emit(ldi(5'd16, pa_a[i]));
			emit(ldi(5'd17, pa_b[i]));
			if (i % 2 == 0)
				emit(alu_rr(16'h1400, 5'd16, 5'd17)); // cp
			else
				emit(alu_imm(16'h3000, 5'd16, pa_b[i])); // cpi
			f = cmp_flags(pa_a[i], pa_b[i]);
			for (int s = 0; s < 6; s++)
				branch_check(3'(s), 1'((s + i) % 2), 6'(i * 6 + s), f);
		end
		run_and_check("branch");
	endtask

	task automatic test_load();
		logic [7:0] ly [32];
		logic [7:0] lz [32];
		logic [4:0] q1;
		logic [4:0] q2;
		new_program();
		for (int i = 0; i < 32; i++) begin
			ly[i] = 8'($urandom);
			lz[i] = 8'($urandom);
			ram[16'h0300 + 16'(i)] <= ly[i];
			ram[16'h0380 + 16'(i)] <= lz[i];
		end
		emit(ldi(5'd28, 8'h00));
		emit(ldi(5'd29, 8'h03));
		set_z(16'h0380);
		for (int i = 0; i < 4; i++) begin
			q1 = 5'($urandom);
			q2 = 5'($urandom);
			emit(ldd_std(1'b0, 1'b1, 5'd16, {1'b0, q1}));
			emit(ldd_std(1'b0, 1'b0, 5'd17, {1'b0, q2}));
			emit(alu_rr(16'h0C00, 5'd16, 5'd17));
			store_expect(5'd16, 6'(40 + i), ly[q1] + lz[q2]);
		end
		run_and_check("load");
	endtask

	task automatic test_jump();
		logic [7:0]  n;
		logic [15:0] top;
		logic [15:0] off;
		n = 8'(1 + $urandom % 8);
		new_program();
		set_z(16'h0400);
		emit(ldi(5'd20, n));
		emit(rjmp_to(12'd1));
		emit(ldd_std(1'b1, 1'b0, 5'd20, 6'd2)); // jumped over
		top = pa;
		emit(ldd_std(1'b1, 1'b0, 5'd20, 6'd0)); // loop body stores the count
		emit(alu_imm(16'h5000, 5'd20, 8'd1));
		emit(branch_on(1'b1, 3'd1, 7'd1));       // leave once the count hits zero
		off = top - pa - 16'd1;
		emit(rjmp_to(off[11:0]));
		for (int i = int'(n); i > 0; i--) begin
			exp_addr.push_back(zbase);
			exp_data.push_back(8'(i));
		end
		store_expect(5'd20, 6'd1, 8'd0);
		run_and_check("jump");
	endtask

	initial begin
		void'($urandom(32'h589b));
		RST <= 1'b1;
		prog_data <= 16'h0000;
		data_rdata <= 8'h00;
		for (int a = 0; a < 65536; a++)
			ram[16'(a)] <= 8'(a) ^ 8'(a >> 8) ^ 8'h5a;
		test_store();
		test_arith();
		test_arith();
		test_logic();
		test_branch();
		test_load();
		test_jump();
		$display("tests done, %0d errors", errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

/* avr_core.f */
+incdir+hw
hw/avr_pkg.sv
hw/avr_fetch.sv
hw/avr_decode.sv
hw/avr_regfile.sv
hw/avr_alu.sv
hw/avr_sequencer.sv
hw/avr_core.sv
bench/avr_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the core testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f avr_core.f \
	--top-module avr_core_tb -Mdir obj_dir -o avr_core_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/avr_core_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^NO ERRORS$"; then
	exit 0
fi
exit 1
